// File: flist.f
dec_pkg.sv
stage_reg.sv
insn_decoder.sv
decode_lane.sv
insn_splitter.sv
uop_merger.sv
decode_cluster.sv
tb_decode_cluster_assertions.sv
tb_decode_cluster.sv

// File: Bender.yml
package:
  name: decode_cluster

sources:
  - dec_pkg.sv
  - stage_reg.sv
  - insn_decoder.sv
  - decode_lane.sv
  - insn_splitter.sv
  - uop_merger.sv
  - decode_cluster.sv
  - target: test
    files:
      - tb_decode_cluster_assertions.sv
      - tb_decode_cluster.sv

// File: tb_decode_cluster.sv
module tb_decode_cluster;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_LANES   = 4;
  localparam int TOTAL_WORDS = 40 + 40 + 7 + 200;
  localparam int TIMEOUT_NS  = TOTAL_WORDS * 40 * 20;

  logic           in_clk;
  logic           arst_n;
  logic           in_valid;
  logic           in_ready;
  dec_pkg::insn_t in_insn;
  logic           out_valid;
  logic           out_ready;
  dec_pkg::uop_t  out_uop;

  dec_pkg::uop_t  expected [$];
  dec_pkg::uop_t  exp_uop;
  int             value_errors = 0;
  int             other_errors = 0;
  int             n_in = 0;
  int             n_out = 0;

  decode_cluster #(
    .NUM_LANES (NUM_LANES)
  ) i_decode_cluster (
    .in_clk    (in_clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_insn   (in_insn),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_uop   (out_uop)
  );

  bind decode_cluster tb_decode_cluster_assertions i_assertions (.*);

  initial begin
    in_clk = 1'b0;
    forever #20 in_clk = ~in_clk;
  end

  // Random word for the given opcode with all fields from one draw.
  function automatic dec_pkg::insn_t make_word(dec_pkg::opcode_t op);
    logic [31:0] r;
    r = $urandom();
    case (op)
      dec_pkg::OP_STUR:   return {11'b1111_1000_000, r[20:12], 2'b00, r[9:0]};
      dec_pkg::OP_MOVK:   return {9'b1111_0010_1, r[22:0]};
      dec_pkg::OP_ADRP:   return {1'b1, r[30:29], 5'b10000, r[23:0]};
      dec_pkg::OP_ADD:    return {9'b1001_0001_0, r[22:0]};
      dec_pkg::OP_SUB:    return {9'b1101_0001_0, r[22:0]};
      dec_pkg::OP_ADDS:   return {11'b1010_1011_000, r[20:0]};
      dec_pkg::OP_SUBS:   return {11'b1110_1011_000, r[20:0]};
      dec_pkg::OP_ANDS:   return {11'b1110_1010_000, r[20:0]};
      dec_pkg::OP_ORR:    return {11'b1010_1010_000, r[20:0]};
      dec_pkg::OP_ORN:    return {11'b1010_1010_001, r[20:0]};
      dec_pkg::OP_EOR:    return {11'b1100_1010_000, r[20:0]};
      dec_pkg::OP_CSEL:   return {11'b1001_1010_100, r[20:12], 2'b00, r[9:0]};
      dec_pkg::OP_CSINC:  return {11'b1001_1010_100, r[20:12], 2'b01, r[9:0]};
      dec_pkg::OP_CSINV:  return {11'b1101_1010_100, r[20:12], 2'b00, r[9:0]};
      dec_pkg::OP_CSNEG:  return {11'b1101_1010_100, r[20:12], 2'b01, r[9:0]};
      dec_pkg::OP_B_COND: return {8'b0101_0100, r[23:5], 1'b0, r[3:0]};
      dec_pkg::OP_BL:     return {6'b100101, r[25:0]};
      dec_pkg::OP_CBZ:    return {8'b1011_0100, r[23:0]};
      dec_pkg::OP_RET:    return {22'b1101_0110_0101_1111_0000_00, r[9:5], 5'b00000};
      dec_pkg::OP_NOP:    return 32'hD503_201F;
      default:            return 32'h0000_0000;
    endcase
  endfunction

  // Expected micro-op from the decode rules for a known opcode.
  function automatic dec_pkg::uop_t expect_uop(dec_pkg::opcode_t op, dec_pkg::insn_t w);
    dec_pkg::uop_t u;
    u        = '0;
    u.opcode = op;
    case (op)
      dec_pkg::OP_STUR: u.imm = 64'(w[20:12]);
      dec_pkg::OP_ADD, dec_pkg::OP_SUB, dec_pkg::OP_UBFM, dec_pkg::OP_SBFM:
        u.imm = 64'(w[21:10]);
      dec_pkg::OP_MOVK: u.imm = 64'(w[20:5]);
      dec_pkg::OP_ADRP: u.imm = 64'({w[23:5], w[30:29]}) << 12;
      default: u.imm = '0;
    endcase
    if (op == dec_pkg::OP_BL) begin
      u.dst = 5'd30;
    end else if (!(op inside {dec_pkg::OP_B, dec_pkg::OP_BR, dec_pkg::OP_B_COND,
                              dec_pkg::OP_CBZ, dec_pkg::OP_CBNZ, dec_pkg::OP_RET,
                              dec_pkg::OP_STUR, dec_pkg::OP_STP, dec_pkg::OP_NOP,
                              dec_pkg::OP_HLT, dec_pkg::OP_ERR})) begin
      u.dst = w[4:0];
    end
    if (op inside {dec_pkg::OP_CBZ, dec_pkg::OP_CBNZ}) begin
      u.src1 = w[4:0];
    end else if (!(op inside {dec_pkg::OP_MOVK, dec_pkg::OP_ADR, dec_pkg::OP_ADRP,
                              dec_pkg::OP_B, dec_pkg::OP_B_COND, dec_pkg::OP_BL,
                              dec_pkg::OP_NOP, dec_pkg::OP_HLT, dec_pkg::OP_ERR})) begin
      u.src1 = w[9:5];
    end
    u.uses_nzcv = op inside {dec_pkg::OP_B_COND, dec_pkg::OP_CSEL, dec_pkg::OP_CSINC,
                             dec_pkg::OP_CSINV, dec_pkg::OP_CSNEG};
    if (op == dec_pkg::OP_STUR) begin
      u.src2 = w[4:0];
    end else if (u.uses_nzcv && op != dec_pkg::OP_B_COND ||
                 op inside {dec_pkg::OP_ADDS, dec_pkg::OP_SUBS, dec_pkg::OP_ORN,
                            dec_pkg::OP_ORR, dec_pkg::OP_EOR, dec_pkg::OP_ANDS}) begin
      u.src2 = w[20:16];
    end
    u.fu = (op inside {dec_pkg::OP_STUR, dec_pkg::OP_LDP, dec_pkg::OP_STP}) ?
           dec_pkg::FU_LS : dec_pkg::FU_ALU;
    case (op)
      dec_pkg::OP_SUB, dec_pkg::OP_SUBS: u.fu_op = dec_pkg::FU_OP_MINUS;
      dec_pkg::OP_ORN:   u.fu_op = dec_pkg::FU_OP_ORN;
      dec_pkg::OP_ORR:   u.fu_op = dec_pkg::FU_OP_OR;
      dec_pkg::OP_EOR:   u.fu_op = dec_pkg::FU_OP_EOR;
      dec_pkg::OP_ANDS:  u.fu_op = dec_pkg::FU_OP_AND;
      dec_pkg::OP_UBFM:  u.fu_op = dec_pkg::FU_OP_UBFM;
      dec_pkg::OP_SBFM:  u.fu_op = dec_pkg::FU_OP_SBFM;
      dec_pkg::OP_MOVK:  u.fu_op = dec_pkg::FU_OP_MOV;
      dec_pkg::OP_CSEL:  u.fu_op = dec_pkg::FU_OP_CSEL;
      dec_pkg::OP_CSINC: u.fu_op = dec_pkg::FU_OP_CSINC;
      dec_pkg::OP_CSINV: u.fu_op = dec_pkg::FU_OP_CSINV;
      dec_pkg::OP_CSNEG: u.fu_op = dec_pkg::FU_OP_CSNEG;
      default:           u.fu_op = dec_pkg::FU_OP_PLUS;
    endcase
    u.set_nzcv = op inside {dec_pkg::OP_ADDS, dec_pkg::OP_SUBS, dec_pkg::OP_ANDS};
    u.use_imm  = op inside {dec_pkg::OP_STUR, dec_pkg::OP_LDP, dec_pkg::OP_STP,
                            dec_pkg::OP_MOVK, dec_pkg::OP_ADR, dec_pkg::OP_ADRP,
                            dec_pkg::OP_ADD, dec_pkg::OP_SUB, dec_pkg::OP_AND,
                            dec_pkg::OP_UBFM, dec_pkg::OP_SBFM, dec_pkg::OP_B,
                            dec_pkg::OP_BR, dec_pkg::OP_B_COND, dec_pkg::OP_BL,
                            dec_pkg::OP_BLR};
    if (op == dec_pkg::OP_B_COND) begin
      u.cond = dec_pkg::cond_t'(w[3:0]);
    end else if (u.uses_nzcv) begin
      u.cond = dec_pkg::cond_t'(w[15:12]);
    end
    return u;
  endfunction

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_opcode(dec_pkg::opcode_t got, dec_pkg::opcode_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("Error: out_uop.opcode got 0x%0h expected 0x%0h", got, exp);
    end
  endtask

  task automatic check_gpr(string name, dec_pkg::gpr_idx_t got, dec_pkg::gpr_idx_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("Error: out_uop.%s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_imm(logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("Error: out_uop.imm got 0x%0h expected 0x%0h", got, exp);
    end
  endtask

  task automatic check_flags(dec_pkg::uop_t got, dec_pkg::uop_t exp);
    check_bit("out_uop.use_imm", got.use_imm, exp.use_imm);
    check_bit("out_uop.set_nzcv", got.set_nzcv, exp.set_nzcv);
    check_bit("out_uop.uses_nzcv", got.uses_nzcv, exp.uses_nzcv);
    check_bit("out_uop.fu", got.fu, exp.fu);
    if (got.fu_op !== exp.fu_op) begin
      value_errors++;
      $display("Error: out_uop.fu_op got 0x%0h expected 0x%0h", got.fu_op, exp.fu_op);
    end
  endtask

  task automatic check_cond(dec_pkg::cond_t got, dec_pkg::cond_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("Error: out_uop.cond got 0x%0h expected 0x%0h", got, exp);
    end
  endtask

  // Sampled mid-cycle. The transfer itself lands on the next rising edge.
  always @(negedge in_clk) begin
    if (arst_n && out_valid && out_ready) begin
      n_out++;
      if (expected.size() == 0) begin
        other_errors++;
        $display("A micro-op came out while no word was outstanding");
      end else begin
        exp_uop = expected.pop_front();
        check_opcode(out_uop.opcode, exp_uop.opcode);
        check_gpr("dst", out_uop.dst, exp_uop.dst);
        check_gpr("src1", out_uop.src1, exp_uop.src1);
        check_gpr("src2", out_uop.src2, exp_uop.src2);
        check_imm(out_uop.imm, exp_uop.imm);
        check_flags(out_uop, exp_uop);
        check_cond(out_uop.cond, exp_uop.cond);
      end
    end
  end

  // Entered and left 2 ns after a rising edge.
  task automatic send_word(dec_pkg::opcode_t op, dec_pkg::insn_t w);
    logic accepted;
    in_valid = 1'b1;
    in_insn  = w;
    do begin
      @(negedge in_clk);
      accepted = in_ready;
      if (accepted) begin
        expected.push_back(expect_uop(op, w));
        n_in++;
      end
      @(posedge in_clk);
      #2;
    end while (!accepted);
    in_valid = 1'b0;
  endtask

  task automatic drain;
    while (expected.size() != 0) begin
      @(posedge in_clk);
    end
    #2;
  endtask

  task automatic test_reset;
    repeat (7) begin
      @(negedge in_clk);
      check_bit("out_valid", out_valid, 1'b0);
      check_bit("in_ready", in_ready, 1'b1);
    end
    @(posedge in_clk);
    #2;
    arst_n = 1'b1;
    @(negedge in_clk);
    check_bit("out_valid", out_valid, 1'b0);
    check_bit("in_ready", in_ready, 1'b1);
    @(posedge in_clk);
    #2;
    out_ready = 1'b1;
  endtask

  task automatic test_imm_forms;
    dec_pkg::opcode_t ops [5] = '{dec_pkg::OP_ADD, dec_pkg::OP_SUB, dec_pkg::OP_MOVK,
                                  dec_pkg::OP_ADRP, dec_pkg::OP_STUR};
    foreach (ops[i]) begin
      repeat (8) send_word(ops[i], make_word(ops[i]));
    end
    drain();
  endtask

  task automatic test_reg_forms;
    dec_pkg::opcode_t ops [10] = '{dec_pkg::OP_ADDS, dec_pkg::OP_SUBS, dec_pkg::OP_ANDS,
                                   dec_pkg::OP_ORR, dec_pkg::OP_ORN, dec_pkg::OP_EOR,
                                   dec_pkg::OP_CSEL, dec_pkg::OP_CSINC,
                                   dec_pkg::OP_CSINV, dec_pkg::OP_CSNEG};
    foreach (ops[i]) begin
      repeat (4) send_word(ops[i], make_word(ops[i]));
    end
    drain();
  endtask

  task automatic test_branches;
    send_word(dec_pkg::OP_B_COND, make_word(dec_pkg::OP_B_COND));
    send_word(dec_pkg::OP_BL, make_word(dec_pkg::OP_BL));
    send_word(dec_pkg::OP_CBZ, make_word(dec_pkg::OP_CBZ));
    send_word(dec_pkg::OP_RET, make_word(dec_pkg::OP_RET));
    send_word(dec_pkg::OP_NOP, make_word(dec_pkg::OP_NOP));
    // Two words that match no pattern.
    send_word(dec_pkg::OP_ERR, 32'h0000_0000);
    send_word(dec_pkg::OP_ERR, 32'hFFFF_FFFF);
    drain();
  endtask

  task automatic test_backpressure;
    dec_pkg::opcode_t legal [20] = '{
      dec_pkg::OP_STUR, dec_pkg::OP_MOVK, dec_pkg::OP_ADRP, dec_pkg::OP_ADD,
      dec_pkg::OP_SUB, dec_pkg::OP_ADDS, dec_pkg::OP_SUBS, dec_pkg::OP_ANDS,
      dec_pkg::OP_ORR, dec_pkg::OP_ORN, dec_pkg::OP_EOR, dec_pkg::OP_CSEL,
      dec_pkg::OP_CSINC, dec_pkg::OP_CSINV, dec_pkg::OP_CSNEG, dec_pkg::OP_B_COND,
      dec_pkg::OP_BL, dec_pkg::OP_CBZ, dec_pkg::OP_RET, dec_pkg::OP_NOP};
    dec_pkg::opcode_t op;
    bit               sending_done;
    sending_done = 1'b0;
    fork
      begin
        repeat (200) begin
          op = legal[$urandom_range(19)];
          send_word(op, make_word(op));
        end
        sending_done = 1'b1;
      end
      while (!sending_done) begin
        @(posedge in_clk);
        #2;
        out_ready = 1'($urandom_range(1));
      end
    join
    out_ready = 1'b1;
    drain();
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns with %0d of %0d micro-ops out",
             TIMEOUT_NS, n_out, n_in);
    $display("test failed");
    $finish;
  end

  initial begin
    int total;
    void'($urandom(32'h882e_1f1f));
    arst_n    = 1'b0;
    in_valid  = 1'b0;
    in_insn   = '0;
    out_ready = 1'b0;
    test_reset();
    test_imm_forms();
    test_reg_forms();
    test_branches();
    test_backpressure();
    if (n_out != n_in) begin
      other_errors++;
      $display("Count mismatch, %0d words in and %0d micro-ops out", n_in, n_out);
    end
    total = value_errors + other_errors + i_decode_cluster.i_assertions.fail_count;
    $display("Summary: %0d value errors, %0d other errors, %0d assertion failures",
             value_errors, other_errors, i_decode_cluster.i_assertions.fail_count);
    if (total == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule : tb_decode_cluster

// File: tb_decode_cluster_assertions.sv
module tb_decode_cluster_assertions (
  input logic          in_clk,
  input logic          arst_n,
  input logic          in_ready,
  input logic          out_valid,
  input logic          out_ready,
  input dec_pkg::uop_t out_uop
);

  timeunit 1ns;
  timeprecision 100ps;

  // Read by the testbench at the end of the run.
  int fail_count = 0;

  // A micro-op on offer stays put until the consumer takes it.
  assert property (@(posedge in_clk) disable iff (!arst_n)
                   out_valid && !out_ready |=> out_valid && $stable(out_uop))
  else begin
    fail_count++;
    $error("out_valid dropped or out_uop changed before out_ready");
  end

  assert property (@(posedge in_clk) !arst_n |-> !out_valid)
  else begin
    fail_count++;
    $error("out_valid high while reset is asserted");
  end

  // First edge after release.
  assert property (@(posedge in_clk) $rose(arst_n) |-> in_ready)
  else begin
    fail_count++;
    $error("in_ready low in the first cycle after reset");
  end

endmodule : tb_decode_cluster_assertions

// File: decode_cluster.sv
module decode_cluster #(
  parameter int NUM_LANES = 4
) (
  input  logic           in_clk,
  input  logic           arst_n,
  input  logic           in_valid,
  output logic           in_ready,
  input  dec_pkg::insn_t in_insn,
  output logic           out_valid,
  input  logic           out_ready,
  output dec_pkg::uop_t  out_uop
);

  logic [NUM_LANES-1:0] lane_in_valid;
  logic [NUM_LANES-1:0] lane_in_ready;
  dec_pkg::insn_t       lane_in_insn;
  logic [NUM_LANES-1:0] lane_out_valid;
  logic [NUM_LANES-1:0] lane_out_ready;
  dec_pkg::uop_t        lane_out_uop [NUM_LANES];

  insn_splitter #(
    .NUM_LANES (NUM_LANES)
  ) i_splitter (
    .in_clk        (in_clk),
    .arst_n        (arst_n),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .in_insn       (in_insn),
    .lane_in_valid (lane_in_valid),
    .lane_in_ready (lane_in_ready),
    .lane_in_insn  (lane_in_insn)
  );

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    decode_lane i_lane (
      .in_clk    (in_clk),
      .arst_n    (arst_n),
      .in_valid  (lane_in_valid[i]),
      .in_ready  (lane_in_ready[i]),
      .in_insn   (lane_in_insn),
      .out_valid (lane_out_valid[i]),
      .out_ready (lane_out_ready[i]),
      .out_uop   (lane_out_uop[i])
    );
  end

  uop_merger #(
    .NUM_LANES (NUM_LANES)
  ) i_merger (
    .in_clk         (in_clk),
    .arst_n         (arst_n),
    .lane_out_valid (lane_out_valid),
    .lane_out_ready (lane_out_ready),
    .lane_out_uop   (lane_out_uop),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_uop        (out_uop)
  );

endmodule : decode_cluster

// File: uop_merger.sv
module uop_merger #(
  parameter int NUM_LANES = 4
) (
  input  logic                 in_clk,
  input  logic                 arst_n,
  input  logic [NUM_LANES-1:0] lane_out_valid,
  output logic [NUM_LANES-1:0] lane_out_ready,
  input  dec_pkg::uop_t        lane_out_uop [NUM_LANES],
  output logic                 out_valid,
  input  logic                 out_ready,
  output dec_pkg::uop_t        out_uop
);

  localparam int PTR_W = $clog2(NUM_LANES);

  logic [PTR_W-1:0] rd_ptr;

  // Drain in the order the splitter filled.
  assign out_valid = lane_out_valid[rd_ptr];
  assign out_uop   = lane_out_uop[rd_ptr];

  always_comb begin
    lane_out_ready         = '0;
    lane_out_ready[rd_ptr] = out_ready;
  end

  always_ff @(posedge in_clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr <= '0;
    end else if (out_valid && out_ready) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule : uop_merger

// File: insn_splitter.sv
module insn_splitter #(
  parameter int NUM_LANES = 4
) (
  input  logic                 in_clk,
  input  logic                 arst_n,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  dec_pkg::insn_t       in_insn,
  output logic [NUM_LANES-1:0] lane_in_valid,
  input  logic [NUM_LANES-1:0] lane_in_ready,
  output dec_pkg::insn_t       lane_in_insn
);

  localparam int PTR_W = $clog2(NUM_LANES);

  logic [PTR_W-1:0] wr_ptr;

  // Every lane sees the word; only the selected one sees valid.
  assign lane_in_insn = in_insn;
  assign in_ready     = lane_in_ready[wr_ptr];

  always_comb begin
    lane_in_valid         = '0;
    lane_in_valid[wr_ptr] = in_valid;
  end

  // Lane count is a power of two, so the pointer wraps by itself.
  always_ff @(posedge in_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
    end else if (in_valid && in_ready) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

endmodule : insn_splitter

// File: decode_lane.sv
module decode_lane (
  input  logic           in_clk,
  input  logic           arst_n,
  input  logic           in_valid,
  output logic           in_ready,
  input  dec_pkg::insn_t in_insn,
  output logic           out_valid,
  input  logic           out_ready,
  output dec_pkg::uop_t  out_uop
);

  logic           insn_valid;
  logic           insn_ready;
  dec_pkg::insn_t insn_q;
  dec_pkg::uop_t  uop_d;

  // Raw word stage.
  stage_reg #(
    .payload_t (dec_pkg::insn_t)
  ) i_insn_reg (
    .in_clk    (in_clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_insn),
    .out_valid (insn_valid),
    .out_ready (insn_ready),
    .out_data  (insn_q)
  );

  insn_decoder i_decoder (
    .insn (insn_q),
    .uop  (uop_d)
  );

  // Decoded micro-op stage.
  stage_reg #(
    .payload_t (dec_pkg::uop_t)
  ) i_uop_reg (
    .in_clk    (in_clk),
    .arst_n    (arst_n),
    .in_valid  (insn_valid),
    .in_ready  (insn_ready),
    .in_data   (uop_d),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_uop)
  );

endmodule : decode_lane

// File: insn_decoder.sv
module insn_decoder (
  input  dec_pkg::insn_t insn,
  output dec_pkg::uop_t  uop
);

  dec_pkg::opcode_t op;

  // Pattern match, first hit wins. Encodings follow the A64 manual.
  always_comb begin
    casez (insn)
      32'b1111_1000_000?_????_????_00??_????_????: op = dec_pkg::OP_STUR;
      32'b1010_1000_11??_????_????_????_????_????: op = dec_pkg::OP_LDP;
      32'b1010_1001_00??_????_????_????_????_????: op = dec_pkg::OP_STP;
      32'b1111_0010_1???_????_????_????_????_????: op = dec_pkg::OP_MOVK;
      32'b0??1_0000_????_????_????_????_????_????: op = dec_pkg::OP_ADR;
      32'b1??1_0000_????_????_????_????_????_????: op = dec_pkg::OP_ADRP;
      32'b1001_1010_100?_????_????_01??_????_????: op = dec_pkg::OP_CSINC;
      32'b1101_1010_100?_????_????_00??_????_????: op = dec_pkg::OP_CSINV;
      32'b1101_1010_100?_????_????_01??_????_????: op = dec_pkg::OP_CSNEG;
      32'b1001_1010_100?_????_????_00??_????_????: op = dec_pkg::OP_CSEL;
      32'b1001_0001_0???_????_????_????_????_????: op = dec_pkg::OP_ADD;
      32'b1010_1011_000?_????_????_????_????_????: op = dec_pkg::OP_ADDS;
      32'b1101_0001_0???_????_????_????_????_????: op = dec_pkg::OP_SUB;
      32'b1110_1011_000?_????_????_????_????_????: op = dec_pkg::OP_SUBS;
      32'b1010_1010_001?_????_????_????_????_????: op = dec_pkg::OP_ORN;
      32'b1010_1010_000?_????_????_????_????_????: op = dec_pkg::OP_ORR;
      32'b1100_1010_000?_????_????_????_????_????: op = dec_pkg::OP_EOR;
      32'b1001_0010_00??_????_????_????_????_????: op = dec_pkg::OP_AND;
      32'b1110_1010_000?_????_????_????_????_????: op = dec_pkg::OP_ANDS;
      32'b1101_0011_01??_????_????_????_????_????: op = dec_pkg::OP_UBFM;
      32'b1001_0011_01??_????_????_????_????_????: op = dec_pkg::OP_SBFM;
      32'b0001_01??_????_????_????_????_????_????: op = dec_pkg::OP_B;
      32'b0101_0100_????_????_????_????_???0_????: op = dec_pkg::OP_B_COND;
      32'b1001_01??_????_????_????_????_????_????: op = dec_pkg::OP_BL;
      32'b1101_0110_0011_1111_0000_00??_???0_0000: op = dec_pkg::OP_BLR;
      32'b1101_0110_0001_1111_0000_00??_???0_0000: op = dec_pkg::OP_BR;
      32'b1011_0101_????_????_????_????_????_????: op = dec_pkg::OP_CBNZ;
      32'b1011_0100_????_????_????_????_????_????: op = dec_pkg::OP_CBZ;
      32'b1101_0110_0101_1111_0000_00??_???0_0000: op = dec_pkg::OP_RET;
      32'b1101_0101_0000_0011_0010_0000_0001_1111: op = dec_pkg::OP_NOP;
      32'b1101_0100_010?_????_????_????_???0_0000: op = dec_pkg::OP_HLT;
      default:                                     op = dec_pkg::OP_ERR;
    endcase
  end

  always_comb begin
    uop        = '0;
    uop.opcode = op;

    case (op)
      dec_pkg::OP_STUR: uop.imm = {55'd0, insn[20:12]};
      dec_pkg::OP_ADD, dec_pkg::OP_SUB, dec_pkg::OP_UBFM, dec_pkg::OP_SBFM:
        uop.imm = {52'd0, insn[21:10]};
      dec_pkg::OP_MOVK: uop.imm = {48'd0, insn[20:5]};
      // Page offset, already scaled to bytes.
      dec_pkg::OP_ADRP: uop.imm = {31'd0, insn[23:5], insn[30:29], 12'h000};
      default:          uop.imm = '0;
    endcase

    // Link register for BL; no destination for stores, plain branches and specials.
    case (op)
      dec_pkg::OP_BL: uop.dst = 5'd30;
      dec_pkg::OP_B, dec_pkg::OP_BR, dec_pkg::OP_B_COND, dec_pkg::OP_CBZ,
      dec_pkg::OP_CBNZ, dec_pkg::OP_RET, dec_pkg::OP_STUR, dec_pkg::OP_STP,
      dec_pkg::OP_NOP, dec_pkg::OP_HLT, dec_pkg::OP_ERR:
        uop.dst = '0;
      default: uop.dst = insn[4:0];
    endcase

    // Compare-and-branch tests the register held in Rt.
    case (op)
      dec_pkg::OP_CBZ, dec_pkg::OP_CBNZ: uop.src1 = insn[4:0];
      dec_pkg::OP_MOVK, dec_pkg::OP_ADR, dec_pkg::OP_ADRP, dec_pkg::OP_B,
      dec_pkg::OP_B_COND, dec_pkg::OP_BL, dec_pkg::OP_NOP, dec_pkg::OP_HLT,
      dec_pkg::OP_ERR:
        uop.src1 = '0;
      default: uop.src1 = insn[9:5];
    endcase

    case (op)
      dec_pkg::OP_STUR: uop.src2 = insn[4:0];
      dec_pkg::OP_ADDS, dec_pkg::OP_SUBS, dec_pkg::OP_ORN, dec_pkg::OP_ORR,
      dec_pkg::OP_EOR, dec_pkg::OP_ANDS, dec_pkg::OP_CSEL, dec_pkg::OP_CSINC,
      dec_pkg::OP_CSINV, dec_pkg::OP_CSNEG:
        uop.src2 = insn[20:16];
      default: uop.src2 = '0;
    endcase

    case (op)
      dec_pkg::OP_STUR, dec_pkg::OP_LDP, dec_pkg::OP_STP: uop.fu = dec_pkg::FU_LS;
      default: uop.fu = dec_pkg::FU_ALU;
    endcase

    case (op)
      dec_pkg::OP_SUB, dec_pkg::OP_SUBS: uop.fu_op = dec_pkg::FU_OP_MINUS;
      dec_pkg::OP_ORN:   uop.fu_op = dec_pkg::FU_OP_ORN;
      dec_pkg::OP_ORR:   uop.fu_op = dec_pkg::FU_OP_OR;
      dec_pkg::OP_EOR:   uop.fu_op = dec_pkg::FU_OP_EOR;
      dec_pkg::OP_ANDS:  uop.fu_op = dec_pkg::FU_OP_AND;
      dec_pkg::OP_UBFM:  uop.fu_op = dec_pkg::FU_OP_UBFM;
      dec_pkg::OP_SBFM:  uop.fu_op = dec_pkg::FU_OP_SBFM;
      dec_pkg::OP_MOVK:  uop.fu_op = dec_pkg::FU_OP_MOV;
      dec_pkg::OP_CSEL:  uop.fu_op = dec_pkg::FU_OP_CSEL;
      dec_pkg::OP_CSINC: uop.fu_op = dec_pkg::FU_OP_CSINC;
      dec_pkg::OP_CSINV: uop.fu_op = dec_pkg::FU_OP_CSINV;
      dec_pkg::OP_CSNEG: uop.fu_op = dec_pkg::FU_OP_CSNEG;
      default:           uop.fu_op = dec_pkg::FU_OP_PLUS;
    endcase

    uop.set_nzcv = op inside {dec_pkg::OP_ADDS, dec_pkg::OP_SUBS, dec_pkg::OP_ANDS};
    uop.uses_nzcv = op inside {dec_pkg::OP_B_COND, dec_pkg::OP_CSEL, dec_pkg::OP_CSINC,
                               dec_pkg::OP_CSINV, dec_pkg::OP_CSNEG};
    uop.use_imm = op inside {dec_pkg::OP_STUR, dec_pkg::OP_LDP, dec_pkg::OP_STP,
                             dec_pkg::OP_MOVK, dec_pkg::OP_ADR, dec_pkg::OP_ADRP,
                             dec_pkg::OP_ADD, dec_pkg::OP_SUB, dec_pkg::OP_AND,
                             dec_pkg::OP_UBFM, dec_pkg::OP_SBFM, dec_pkg::OP_B,
                             dec_pkg::OP_BR, dec_pkg::OP_B_COND, dec_pkg::OP_BL,
                             dec_pkg::OP_BLR};

    // Branch condition sits low, select condition in bits 15:12.
    if (op == dec_pkg::OP_B_COND) begin
      uop.cond = dec_pkg::cond_t'(insn[3:0]);
    end else if (uop.uses_nzcv) begin
      uop.cond = dec_pkg::cond_t'(insn[15:12]);
    end
  end

endmodule : insn_decoder

// File: stage_reg.sv
module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     in_clk,
  input  logic     arst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     full;
  payload_t data_q;

  // Accept while empty, or while the held entry leaves in this cycle.
  assign in_ready  = !full || out_ready;
  assign out_valid = full;
  assign out_data  = data_q;

  always_ff @(posedge in_clk or negedge arst_n) begin
    if (!arst_n) begin
      full <= 1'b0;
    end else if (in_valid && in_ready) begin
      full <= 1'b1;
    end else if (out_ready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge in_clk) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

endmodule : stage_reg

// File: dec_pkg.sv
package dec_pkg;

  // One raw instruction word from fetch.
  typedef logic [31:0] insn_t;

  // General register index, X0 to X30 plus XZR/SP.
  typedef logic [4:0] gpr_idx_t;

  // Decoded opcode. OP_ERR marks a word that matches no pattern.
  typedef enum logic [5:0] {
    OP_STUR, OP_LDP, OP_STP, OP_MOVK, OP_ADR, OP_ADRP,
    OP_CSINC, OP_CSINV, OP_CSNEG, OP_CSEL,
    OP_ADD, OP_ADDS, OP_SUB, OP_SUBS,
    OP_ORN, OP_ORR, OP_EOR, OP_AND, OP_ANDS,
    OP_UBFM, OP_SBFM,
    OP_B, OP_B_COND, OP_BL, OP_BLR, OP_BR,
    OP_CBNZ, OP_CBZ, OP_RET, OP_NOP, OP_HLT,
    OP_ERR
  } opcode_t;

  // Functional unit that executes the micro-op.
  typedef enum logic {
    FU_ALU,
    FU_LS
  } fu_t;

  // Operation inside the functional unit.
  typedef enum logic [3:0] {
    FU_OP_PLUS, FU_OP_MINUS, FU_OP_ORN, FU_OP_OR, FU_OP_EOR, FU_OP_AND,
    FU_OP_UBFM, FU_OP_SBFM, FU_OP_MOV,
    FU_OP_CSEL, FU_OP_CSINC, FU_OP_CSINV, FU_OP_CSNEG
  } fu_op_t;

  // Arm condition codes, in architectural encoding order.
  typedef enum logic [3:0] {
    C_EQ, C_NE, C_CS, C_CC,
    C_MI, C_PL, C_VS, C_VC,
    C_HI, C_LS, C_GE, C_LT,
    C_GT, C_LE, C_AL, C_NV
  } cond_t;

  // Decoded micro-op handed to rename.
  typedef struct packed {
    opcode_t     opcode;
    fu_t         fu;
    fu_op_t      fu_op;
    gpr_idx_t    dst;
    gpr_idx_t    src1;
    gpr_idx_t    src2;
    logic [63:0] imm;
    logic        use_imm;
    logic        set_nzcv;
    logic        uses_nzcv;
    cond_t       cond;
  } uop_t;

endpackage : dec_pkg
